//--- decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define LANES 4                          // Decode lanes per fetch bundle, 1 to 8
`define XLEN 32                          // Data word width
`define REG_RANGE `XLEN-1:0              // Bit range of one data word
`define CNT_W ($clog2(`LANES + 1))       // Valid count width, holds 0..LANES

`define IMM_I_W 12                       // I and S immediate field width
`define IMM_B_W 13                       // Branch offset width, bit 0 always zero
`define IMM_J_W 21                       // Jump offset width, bit 0 always zero

`define OPC_OP     7'b0110011            // Register-register ALU
`define OPC_OP_IMM 7'b0010011            // Register-immediate ALU
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111

`endif

//--- decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

    // One-hot extension code, same encoding the extender has always used
    typedef enum logic [2:0] {
        EXT_NONE = 3'b000,                   // Invalid code, extender returns zero
        EXT_12   = 3'b001,                   // Sign bit 11
        EXT_13   = 3'b010,                   // Sign bit 12
        EXT_21   = 3'b100                    // Sign bit 20
    } ext_sel_e;

    typedef enum logic [3:0] {
        OP,
        OP_IMM,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        LUI,
        AUIPC,
        ILLEGAL                              // Unknown, compressed, system and CSR opcodes
    } instr_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;                  // Sits in the rd slot at bit 7
        logic [6:0] opcode;
    } b_fmt_t;

    // J pieces laid out in word order, so U reads them back as instr[31:12]
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } ju_fmt_t;

    typedef union packed {
        logic [`REG_RANGE] raw;
        r_fmt_t  r;
        i_fmt_t  i;
        s_fmt_t  s;
        b_fmt_t  b;
        ju_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic              valid;
        logic [`REG_RANGE] pc;
        instr_u            instr;
    } lane_in_t;

    typedef struct packed {
        logic              valid;
        logic [`REG_RANGE] pc;
        instr_class_e      cls;              // Instruction class
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [2:0]        funct3;
        logic [`REG_RANGE] imm;              // Final extended and masked immediate
    } lane_out_t;

endpackage

//--- fetch_splitter.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module fetch_splitter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                bundle_valid,
    input  logic [`REG_RANGE]                   bundle_pc,
    input  logic [`LANES*`XLEN-1:0]             bundle_instr,
    input  logic [`LANES-1:0]                   lane_mask,
    output decode_pkg::lane_in_t [`LANES-1:0]   lanes,
    output logic                                bundle_seen
);

    import decode_pkg::*;

    logic [`LANES-1:0]                 valid_q;   // Per-lane valid, bundle strobe AND mask
    logic [`LANES-1:0][`REG_RANGE]     pc_q;      // Per-lane program counter
    logic [`LANES-1:0][`REG_RANGE]     instr_q;   // Per-lane instruction word

    // Control state, cleared on reset and whenever no bundle arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= '0;
            bundle_seen <= 1'b0;
        end else begin
            valid_q     <= {`LANES{bundle_valid}} & lane_mask;
            bundle_seen <= bundle_valid;                      // Marks arrival even if fully masked
        end
    end

    always_ff @(posedge clk) begin
        if (bundle_valid) begin                               // Payload only moves on a strobe
            for (int k = 0; k < `LANES; k++) begin
                pc_q[k]    <= bundle_pc + `XLEN'(4 * k);      // Word k sits 4k bytes past lane 0
                instr_q[k] <= bundle_instr[k*`XLEN +: `XLEN];
            end
        end
    end

    always_comb begin : pack_lanes
        for (int k = 0; k < `LANES; k++) begin
            lanes[k].valid     = valid_q[k];
            lanes[k].pc        = pc_q[k];
            lanes[k].instr.raw = instr_q[k];
        end
    end

endmodule

//--- immediate_extender.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module immediate_extender (
    input  logic                 [`REG_RANGE] instruction,   // Gathered field, right aligned
    input  logic                              extend_flag,   // Low selects pass-through
    input  decode_pkg::ext_sel_e              sign_extend,   // One-hot field width
    input  logic                 [`REG_RANGE] immediate,     // Pre-formed value for pass-through
    input  logic                              byte_enable,
    input  logic                              halfword_enable,
    input  logic                              word_enable,
    output logic                 [`REG_RANGE] result
);

    import decode_pkg::*;

    logic [`REG_RANGE] extended;                              // Value before size masking

    always_comb begin : extend
        if (extend_flag) begin
            case (sign_extend)
                EXT_12:  extended = {{(`XLEN - `IMM_I_W){instruction[`IMM_I_W-1]}},
                                     instruction[`IMM_I_W-1:0]};
                EXT_13:  extended = {{(`XLEN - `IMM_B_W){instruction[`IMM_B_W-1]}},
                                     instruction[`IMM_B_W-1:0]};
                EXT_21:  extended = {{(`XLEN - `IMM_J_W){instruction[`IMM_J_W-1]}},
                                     instruction[`IMM_J_W-1:0]};
                default: extended = '0;                       // Not a one-hot width
            endcase
        end else begin
            extended = immediate;
        end
    end

    // Byte wins over halfword, a word access keeps every bit
    always_comb begin : size_mask
        if (byte_enable) begin
            result = {{(`XLEN - 8){1'b0}}, extended[7:0]};    // Zero-extend low byte
        end else if (halfword_enable) begin
            result = {{(`XLEN - 16){1'b0}}, extended[15:0]};  // Zero-extend low halfword
        end else begin
            result = extended;                                // Word or no memory access
        end
    end

endmodule

//--- lane_decoder.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module lane_decoder (
    input  decode_pkg::lane_in_t  lane_in,
    output decode_pkg::lane_out_t lane_out
);

    import decode_pkg::*;

    instr_u            ins;                                   // Instruction seen in all formats
    instr_class_e      cls;
    logic [`REG_RANGE] gathered;                              // Immediate bits, right aligned
    logic [`REG_RANGE] pass_imm;                              // Ready-made U immediate
    logic [`REG_RANGE] imm;
    logic              ext_on;
    ext_sel_e          ext_code;
    logic              mem_access;
    logic              byte_en;
    logic              half_en;
    logic              word_en;

    assign ins = lane_in.instr;

    always_comb begin : classify
        case (ins.r.opcode)
            `OPC_OP:     cls = OP;
            `OPC_OP_IMM: cls = OP_IMM;
            `OPC_LOAD:   cls = LOAD;
            `OPC_STORE:  cls = STORE;
            `OPC_BRANCH: cls = BRANCH;
            `OPC_JAL:    cls = JAL;
            `OPC_JALR:   cls = JALR;
            `OPC_LUI:    cls = LUI;
            `OPC_AUIPC:  cls = AUIPC;
            default:     cls = ILLEGAL;                       // Also system, CSR and compressed
        endcase
    end

    always_comb begin : gather
        gathered = '0;
        pass_imm = '0;                                        // OP and ILLEGAL end up with zero
        ext_on   = 1'b0;
        ext_code = EXT_NONE;
        case (cls)
            OP_IMM, LOAD, JALR: begin
                gathered = `XLEN'(ins.i.imm_11_0);
                ext_on   = 1'b1;
                ext_code = EXT_12;
            end
            STORE: begin
                gathered = `XLEN'({ins.s.imm_11_5, ins.s.imm_4_0});   // Split 12-bit offset
                ext_on   = 1'b1;
                ext_code = EXT_12;
            end
            BRANCH: begin
                gathered = `XLEN'({ins.b.imm_12, ins.b.imm_11, ins.b.imm_10_5,
                                   ins.b.imm_4_1, 1'b0});     // Halfword aligned
                ext_on   = 1'b1;
                ext_code = EXT_13;
            end
            JAL: begin
                gathered = `XLEN'({ins.j.imm_20, ins.j.imm_19_12, ins.j.imm_11,
                                   ins.j.imm_10_1, 1'b0});    // Halfword aligned
                ext_on   = 1'b1;
                ext_code = EXT_21;
            end
            LUI, AUIPC: begin
                // Upper 20 bits in place, low 12 zero
                pass_imm = {ins.j.imm_20, ins.j.imm_10_1, ins.j.imm_11,
                            ins.j.imm_19_12, 12'b0};
            end
            default: begin
            end
        endcase
    end

    assign mem_access = (cls == LOAD) || (cls == STORE);      // Only these get a size mask

    always_comb begin : size_select
        byte_en = 1'b0;
        half_en = 1'b0;
        word_en = 1'b0;
        if (mem_access) begin
            case (ins.r.funct3)
                3'd0, 3'd4: byte_en = 1'b1;                   // LB, LBU, SB
                3'd1, 3'd5: half_en = 1'b1;                   // LH, LHU, SH
                3'd2:       word_en = 1'b1;                   // LW, SW
                default: begin
                end
            endcase
        end
    end

    immediate_extender i_imm_ext (
        .instruction     (gathered),
        .extend_flag     (ext_on),
        .sign_extend     (ext_code),
        .immediate       (pass_imm),
        .byte_enable     (byte_en),
        .halfword_enable (half_en),
        .word_enable     (word_en),
        .result          (imm)
    );

    always_comb begin : drive_out
        lane_out.valid  = lane_in.valid;                      // Invalid in, invalid out
        lane_out.pc     = lane_in.pc;
        lane_out.cls    = cls;
        lane_out.rd     = ins.r.rd;                           // Raw fields, every format
        lane_out.rs1    = ins.r.rs1;
        lane_out.rs2    = ins.r.rs2;
        lane_out.funct3 = ins.r.funct3;
        lane_out.imm    = imm;
    end

endmodule

//--- lane_collector.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module lane_collector (
    input  logic                                clk,
    input  logic                                rst,
    input  decode_pkg::lane_out_t [`LANES-1:0]  lanes,
    input  logic                                in_valid,    // Bundle strobe, one cycle late
    output logic                                out_valid,
    output decode_pkg::lane_out_t [`LANES-1:0]  out_slots,
    output logic [`CNT_W-1:0]                   out_count
);

    import decode_pkg::*;

    lane_out_t [`LANES-1:0] packed_slots;                     // Valid lanes moved toward slot 0
    logic [`CNT_W-1:0]      next_count;                       // Also the next free slot index

    // Walk lanes in order so slot order follows lane order
    always_comb begin : compact
        packed_slots = '0;                                    // Unused slots stay zero
        next_count   = '0;
        for (int k = 0; k < `LANES; k++) begin
            if (lanes[k].valid) begin
                packed_slots[next_count] = lanes[k];
                next_count               = next_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_count <= '0;
            out_slots <= '0;                                  // Clears every slot valid bit
        end else begin
            out_valid <= in_valid;                            // Fires even for an all-masked bundle
            out_count <= next_count;
            out_slots <= packed_slots;
        end
    end

endmodule

//--- decode_top.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                bundle_valid,
    input  logic [`REG_RANGE]                   bundle_pc,
    input  logic [`LANES*`XLEN-1:0]             bundle_instr,
    input  logic [`LANES-1:0]                   lane_mask,
    output logic                                out_valid,
    output decode_pkg::lane_out_t [`LANES-1:0]  out_slots,
    output logic [`CNT_W-1:0]                   out_count
);

    import decode_pkg::*;

    lane_in_t  [`LANES-1:0] split_lanes;                      // Registered stage 1
    lane_out_t [`LANES-1:0] dec_lanes;                        // Combinational decode results
    logic                   bundle_seen;

    fetch_splitter i_splitter (
        .clk          (clk),
        .rst          (rst),
        .bundle_valid (bundle_valid),
        .bundle_pc    (bundle_pc),
        .bundle_instr (bundle_instr),
        .lane_mask    (lane_mask),
        .lanes        (split_lanes),
        .bundle_seen  (bundle_seen)
    );

    for (genvar k = 0; k < `LANES; k++) begin : g_lane
        lane_decoder i_lane (
            .lane_in  (split_lanes[k]),
            .lane_out (dec_lanes[k])
        );
    end

    lane_collector i_collector (
        .clk       (clk),
        .rst       (rst),
        .lanes     (dec_lanes),
        .in_valid  (bundle_seen),
        .out_valid (out_valid),
        .out_slots (out_slots),
        .out_count (out_count)
    );

endmodule

//--- tb_decode_top.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_decode_top;

    import decode_pkg::*;

    typedef logic [`LANES*`XLEN-1:0] bundle_t;
    typedef lane_out_t [`LANES-1:0]  slot_arr_t;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    localparam int N_DIRECTED = 8;
    localparam int N_RANDOM   = 200;

    logic                   clk;
    logic                   rst;
    logic                   bundle_valid;
    logic [`REG_RANGE]      bundle_pc;
    bundle_t                bundle_instr;
    logic [`LANES-1:0]      lane_mask;
    logic                   out_valid;
    slot_arr_t              out_slots;
    logic [`CNT_W-1:0]      out_count;

    slot_arr_t              exp_slot_q[$];              // Expected slots, one entry per bundle
    logic [`CNT_W-1:0]      exp_cnt_q[$];
    string                  name_q[$];
    logic [15:0]            lfsr_state    = 16'd44;     // Seed
    logic [6:0]             legal_opc [9] = '{`OPC_OP, `OPC_OP_IMM, `OPC_LOAD, `OPC_STORE,
                                              `OPC_BRANCH, `OPC_JAL, `OPC_JALR, `OPC_LUI,
                                              `OPC_AUIPC};

    decode_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .bundle_valid (bundle_valid),
        .bundle_pc    (bundle_pc),
        .bundle_instr (bundle_instr),
        .lane_mask    (lane_mask),
        .out_valid    (out_valid),
        .out_slots    (out_slots),
        .out_count    (out_count)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);       // One step per bit taken
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [11:0] imm);
        return {imm, 5'd3, f3, 5'd1, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd3, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off);
        return {off[12], off[10:5], 5'd4, 5'd5, 3'd1, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd6, `OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] up);
        return {up, 5'd7, opc};
    endfunction

    // Word k of the bundle repeats the four given words
    function automatic bundle_t make_bundle(input logic [31:0] w0, w1, w2, w3);
        logic [31:0] w [4];
        bundle_t     b;
        w = '{w0, w1, w2, w3};
        b = '0;
        for (int k = 0; k < `LANES; k++) begin
            b[k*`XLEN +: `XLEN] = w[k % 4];
        end
        return b;
    endfunction

    function automatic logic [31:0] size_mask(input logic [31:0] v, input logic [2:0] f3);
        case (f3)
            3'd0, 3'd4: return v & 32'h0000_00ff;     // Byte
            3'd1, 3'd5: return v & 32'h0000_ffff;     // Halfword
            default:    return v;
        endcase
    endfunction

    // Expected decode of one word, straight from the instruction formats
    function automatic lane_out_t ref_lane(input logic [31:0] w, input logic [31:0] pc);
        lane_out_t o;
        o        = '0;
        o.valid  = 1'b1;
        o.pc     = pc;
        o.rd     = w[11:7];
        o.rs1    = w[19:15];
        o.rs2    = w[24:20];
        o.funct3 = w[14:12];
        case (w[6:0])
            `OPC_OP:     o.cls = OP;                      // Imm stays zero
            `OPC_OP_IMM: begin
                o.cls = OP_IMM;
                o.imm = {{20{w[31]}}, w[31:20]};
            end
            `OPC_JALR:   begin
                o.cls = JALR;
                o.imm = {{20{w[31]}}, w[31:20]};
            end
            `OPC_LOAD:   begin
                o.cls = LOAD;
                o.imm = size_mask({{20{w[31]}}, w[31:20]}, w[14:12]);
            end
            `OPC_STORE:  begin
                o.cls = STORE;
                o.imm = size_mask({{20{w[31]}}, w[31:25], w[11:7]}, w[14:12]);
            end
            `OPC_BRANCH: begin
                o.cls = BRANCH;
                o.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            `OPC_JAL:    begin
                o.cls = JAL;
                o.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `OPC_LUI:    begin
                o.cls = LUI;
                o.imm = {w[31:12], 12'b0};
            end
            `OPC_AUIPC:  begin
                o.cls = AUIPC;
                o.imm = {w[31:12], 12'b0};
            end
            default:     o.cls = ILLEGAL;
        endcase
        return o;
    endfunction

    function automatic slot_arr_t ref_bundle(input logic [31:0] pc, input bundle_t instr,
                                             input logic [`LANES-1:0] mask,
                                             output logic [`CNT_W-1:0] cnt);
        slot_arr_t s;
        s   = '0;
        cnt = '0;
        for (int k = 0; k < `LANES; k++) begin
            if (mask[k]) begin                        // Masked lanes leave no gap
                s[cnt] = ref_lane(instr[k*`XLEN +: `XLEN], pc + 32'(4 * k));
                cnt    = cnt + 1'b1;
            end
        end
        return s;
    endfunction

    task automatic check_slot(input string name, input int idx, input lane_out_t exp,
                              input lane_out_t act);
        if (act !== exp) begin
            $display("error %s slot %0d: expected %h, actual %h", name, idx, exp, act);
            report_failure("Decoded slot does not match the reference");
        end
    endtask

    task automatic check_count(input string name, input logic [`CNT_W-1:0] exp,
                               input logic [`CNT_W-1:0] act);
        if (act !== exp) begin
            $display("error %s out_count: expected %0d, actual %0d", name, exp, act);
            report_failure("Valid count does not match the reference");
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s out_valid: expected %b, actual %b", name, exp, act);
            report_failure("Output strobe is not 2 cycles after the bundle strobe");
        end
    endtask

    task automatic send_bundle(input string name, input logic [31:0] pc, input bundle_t instr,
                               input logic [`LANES-1:0] mask);
        logic [`CNT_W-1:0] cnt;
        slot_arr_t         slots;
        @(posedge clk);
        bundle_valid <= 1'b1;
        bundle_pc    <= pc;
        bundle_instr <= instr;
        lane_mask    <= mask;
        slots = ref_bundle(pc, instr, mask, cnt);
        exp_slot_q.push_back(slots);
        exp_cnt_q.push_back(cnt);
        name_q.push_back(name);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            bundle_valid <= 1'b0;
        end
    endtask

    task automatic random_word(output logic [31:0] w);
        logic [31:0] sel;
        logic [31:0] body;
        logic [31:0] opc;
        take_bits(4, sel);
        take_bits(25, body);
        if (sel < 9) begin
            opc = 32'(legal_opc[sel]);
        end else begin
            take_bits(7, opc);                        // Garbage, mostly illegal
        end
        w = {body[24:0], opc[6:0]};
    endtask

    // Sampled on the falling edge, away from the DUT's rising-edge updates
    initial begin : compare
        logic [1:0]        sent_hist;
        logic              exp_v;
        string             name;
        slot_arr_t         exp_slots;
        logic [`CNT_W-1:0] exp_cnt;
        sent_hist = '0;
        forever begin
            @(negedge clk);
            exp_v     = sent_hist[1];                 // Strobe seen two cycles ago
            sent_hist = {sent_hist[0], bundle_valid};
            if (!rst) begin
                check_valid("timing", exp_v, out_valid);
                if (!exp_v) begin
                    check_count("idle", '0, out_count);
                end else begin
                    exp_slots = exp_slot_q.pop_front();
                    exp_cnt   = exp_cnt_q.pop_front();
                    name      = name_q.pop_front();
                    check_count(name, exp_cnt, out_count);
                    for (int k = 0; k < `LANES; k++) begin
                        check_slot(name, k, exp_slots[k], out_slots[k]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #((RST_CYCLES + 2 * (N_DIRECTED + N_RANDOM) + 40) * CLK_PERIOD);
        report_failure("Timeout, DUT outputs stopped arriving");
    end

    initial begin : stimulus
        logic [31:0] w;
        logic [31:0] m;
        logic [31:0] p;
        logic [31:0] g;
        bundle_t     instr;
        rst          = 1'b1;
        bundle_valid = 1'b0;
        bundle_pc    = '0;
        bundle_instr = '0;
        lane_mask    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        idle(3);                                      // Outputs must stay quiet
        // Directed groups back to back
        send_bundle("itype", 32'h0000_1000, make_bundle(enc_i(`OPC_OP_IMM, 3'd0, 12'h7ff),
                    enc_i(`OPC_OP_IMM, 3'd0, 12'hfff), enc_i(`OPC_JALR, 3'd0, 12'h800),
                    enc_i(`OPC_LOAD, 3'd2, 12'h9ab)), '1);
        send_bundle("stype", 32'h0000_2000, make_bundle(enc_s(3'd0, 12'h8f0),
                    enc_s(3'd1, 12'hffe), enc_s(3'd2, 12'h7ff), enc_s(3'd2, 12'h800)), '1);
        send_bundle("btype", 32'h0000_3000, make_bundle(enc_b(13'h0ffe), enc_b(13'h1000),
                    enc_b(13'h1ffe), enc_b(13'h0008)), '1);
        send_bundle("jtype", 32'h0000_4000, make_bundle(enc_j(21'h0ffffe),
                    enc_j(21'h100000), enc_j(21'h1ffffe), enc_j(21'h000800)), '1);
        send_bundle("utype", 32'h0000_5000, make_bundle(enc_u(`OPC_LUI, 20'habcde),
                    enc_u(`OPC_AUIPC, 20'h12345), 32'h00b5_0533, 32'h0000_0073), '1);
        send_bundle("loads", 32'h0000_6000, make_bundle(enc_i(`OPC_LOAD, 3'd0, 12'hfff),
                    enc_i(`OPC_LOAD, 3'd1, 12'hfff), enc_i(`OPC_LOAD, 3'd4, 12'h880),
                    enc_i(`OPC_LOAD, 3'd5, 12'hf00)), '1);
        idle(2);
        send_bundle("all_masked", 32'h0000_7000, make_bundle(enc_s(3'd0, 12'h001),
                    enc_b(13'h0004), enc_j(21'h000010), 32'h0000_4501), '0);
        send_bundle("partial", 32'hffff_fff8, make_bundle(enc_i(`OPC_OP_IMM, 3'd1, 12'h123),
                    32'h0000_4501, enc_s(3'd2, 12'hf0f), enc_u(`OPC_LUI, 20'hfffff)),
                    `LANES'(4'b1010));
        idle(1);
        for (int n = 0; n < N_RANDOM; n++) begin
            for (int k = 0; k < `LANES; k++) begin
                random_word(w);
                instr[k*`XLEN +: `XLEN] = w;
            end
            take_bits(`LANES, m);
            take_bits(30, p);
            send_bundle("random", {p[29:0], 2'b00}, instr, m[`LANES-1:0]);
            take_bits(1, g);
            if (g[0]) begin
                idle(1);                              // Otherwise the next one is back to back
            end
        end
        idle(1);
        while (exp_slot_q.size() != 0) begin
            @(posedge clk);
        end
        idle(4);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- decode_top.f
+incdir+.
decode_pkg.sv
fetch_splitter.sv
immediate_extender.sv
lane_decoder.sv
lane_collector.sv
decode_top.sv
tb_decode_top.sv

//--- Bender.yml
package:
  name: decode_top

export_include_dirs:
  - .

sources:
  - files:
      - decode_pkg.sv
      - fetch_splitter.sv
      - immediate_extender.sv
      - lane_decoder.sv
      - lane_collector.sv
      - decode_top.sv
  - target: test
    files:
      - tb_decode_top.sv
